// File: common/arm_consts.svh
`ifndef ARM_CONSTS_SVH
`define ARM_CONSTS_SVH

// Data-processing opcodes, instr[24:21]
`define OP_AND 4'b0000
`define OP_EOR 4'b0001
`define OP_SUB 4'b0010
`define OP_ADD 4'b0100
`define OP_CMP 4'b1010
`define OP_ORR 4'b1100
`define OP_MOV 4'b1101

// Condition field, instr[31:28]
`define COND_EQ 4'b0000
`define COND_NE 4'b0001
`define COND_CS 4'b0010
`define COND_CC 4'b0011
`define COND_MI 4'b0100
`define COND_PL 4'b0101
`define COND_VS 4'b0110
`define COND_VC 4'b0111
`define COND_HI 4'b1000
`define COND_LS 4'b1001
`define COND_GE 4'b1010
`define COND_LT 4'b1011
`define COND_GT 4'b1100
`define COND_LE 4'b1101
`define COND_AL 4'b1110
`define COND_NV 4'b1111 // Never, also marks a pipeline bubble

// Instruction class, instr[27:26]
`define CLASS_DP  2'b00
`define CLASS_MEM 2'b01
`define CLASS_BR  2'b10

`define REG_PC    4'd15
`define RESET_PC  32'h0000_0000
`define MEM_WORDS 1024

`endif

// File: common/armIsaPkg.sv
package armIsaPkg;

  // One instruction word seen as data processing, load/store or branch
  typedef union packed {
    struct packed {
      logic [3:0]  cond;
      logic [1:0]  cls;
      logic        imm;      // Operand2 is an 8-bit immediate
      logic [3:0]  opcode;
      logic        s;        // Set flags
      logic [3:0]  rn;
      logic [3:0]  rd;
      logic [11:0] operand2; // Rm in [3:0] when imm is low
    } dp;
    struct packed {
      logic [3:0]  cond;
      logic [1:0]  cls;
      logic        imm;      // Low for immediate offset
      logic        p;
      logic        u;        // Add offset when set
      logic        b;
      logic        w;
      logic        l;        // Load when set
      logic [3:0]  rn;
      logic [3:0]  rd;
      logic [11:0] offset;
    } mem;
    struct packed {
      logic [3:0]  cond;
      logic [1:0]  cls;
      logic        one;      // Always 1 for B
      logic        link;
      logic [23:0] offset;   // Word offset, sign extended
    } br;
  } instrU;

endpackage

// File: common/armCondPkg.sv
package armCondPkg;

  `include "arm_consts.svh"

  function automatic logic condPassed(input logic [3:0] cond, input logic [3:0] nzcv);
    logic n, z, c, v;
    logic pass;
    {n, z, c, v} = nzcv;
    case (cond)
      `COND_EQ: pass = z;
      `COND_NE: pass = ~z;
      `COND_CS: pass = c;
      `COND_CC: pass = ~c;
      `COND_MI: pass = n;
      `COND_PL: pass = ~n;
      `COND_VS: pass = v;
      `COND_VC: pass = ~v;
      `COND_HI: pass = c & ~z;
      `COND_LS: pass = ~c | z;
      `COND_GE: pass = (n == v);
      `COND_LT: pass = (n != v);
      `COND_GT: pass = ~z & (n == v);
      `COND_LE: pass = z | (n != v);
      `COND_AL: pass = 1'b1;
      default:  pass = 1'b0; // NV never executes
    endcase
    return pass;
  endfunction

  // C and V only meaningful for ADD, SUB and CMP
  // Logical ops keep the old C and V, the flag writer masks them
  function automatic logic [3:0] aluFlags(input logic [3:0] op, input logic [31:0] a,
                                          input logic [31:0] b, input logic [31:0] result);
    logic [32:0] sum;
    logic carry, ovf;
    sum = {1'b0, a} + {1'b0, b};
    case (op)
      `OP_ADD: begin
        carry = sum[32];
        ovf   = (a[31] == b[31]) && (result[31] != a[31]);
      end
      `OP_SUB, `OP_CMP: begin
        carry = (a >= b); // No borrow
        ovf   = (a[31] != b[31]) && (result[31] != a[31]);
      end
      default: begin
        carry = 1'b0;
        ovf   = 1'b0;
      end
    endcase
    return {result[31], result == 32'd0, carry, ovf};
  endfunction

endpackage

// File: controller/condUnit.sv
`timescale 1ns/1ps

module condUnit import armCondPkg::*; (
  input  logic       clk,
  input  logic       arstN,
  input  logic [3:0] condE,
  input  logic [1:0] flagWriteE, // [1] updates NZ, [0] updates CV
  input  logic [3:0] aluFlagsE,
  output logic       condExE
);

  logic [3:0] flags; // NZCV

  assign condExE = condPassed(condE, flags);

  // Flags only change when the setting instruction itself executes
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flags <= 4'b0000;
    end else begin
      if (flagWriteE[1] && condExE) flags[3:2] <= aluFlagsE[3:2];
      if (flagWriteE[0] && condExE) flags[1:0] <= aluFlagsE[1:0];
    end
  end

endmodule

// File: controller/controller.sv
`timescale 1ns/1ps
`include "arm_consts.svh"

module controller import armIsaPkg::*; (
  input  logic       clk,
  input  logic       arstN,
  input  instrU      instrD,
  input  logic [3:0] aluFlagsE,
  input  logic       flushE,
  input  logic       stallD,
  output logic [1:0] regSrcD,    // [0] Rn is PC, [1] Rm is Rd
  output logic [1:0] immSrcD,
  output logic       aluSrcE,
  output logic [3:0] aluControlE,
  output logic       branchTakenE,
  output logic       memWriteM,
  output logic       dataReqM,
  output logic       regWriteE,
  output logic       regWriteM,
  output logic       regWriteW,
  output logic       memtoRegW,
  output logic [3:0] rdE,
  output logic [3:0] rdM,
  output logic [3:0] rdW,
  output logic       usesRnD,
  output logic       usesRmD
);

  logic       aluSrcD, regWriteD, memWriteD, memtoRegD, branchD;
  logic [3:0] aluControlD;
  logic [1:0] flagWriteD, flagWriteE;
  logic       regWriteRawE, memWriteE, memtoRegE, branchE;
  logic [3:0] condE;
  logic       condExE;
  logic       memtoRegM;

  // Decode
  always_comb begin
    regSrcD     = 2'b00;
    immSrcD     = 2'b00;
    aluSrcD     = 1'b0;
    aluControlD = `OP_ADD;
    regWriteD   = 1'b0;
    memWriteD   = 1'b0;
    memtoRegD   = 1'b0;
    branchD     = 1'b0;
    flagWriteD  = 2'b00;
    usesRnD     = 1'b0;
    usesRmD     = 1'b0;
    if (instrD.dp.cond != `COND_NV) begin // NV word is a bubble
      case (instrD.dp.cls)
        `CLASS_DP: begin
          aluSrcD     = instrD.dp.imm;
          aluControlD = instrD.dp.opcode;
          regWriteD   = 1'b1;
          flagWriteD  = {instrD.dp.s, instrD.dp.s & (instrD.dp.opcode inside
                         {`OP_ADD, `OP_SUB, `OP_CMP})};
          usesRnD     = (instrD.dp.opcode != `OP_MOV);
          usesRmD     = ~instrD.dp.imm;
        end
        `CLASS_MEM: begin
          immSrcD     = 2'b01;
          aluSrcD     = 1'b1;
          aluControlD = instrD.mem.u ? `OP_ADD : `OP_SUB;
          usesRnD     = 1'b1;
          if (instrD.mem.l) begin
            regWriteD = 1'b1;
            memtoRegD = 1'b1;
          end else begin
            memWriteD = 1'b1;
            regSrcD   = 2'b10; // Store data comes from Rd
            usesRmD   = 1'b1;
          end
        end
        `CLASS_BR: begin
          regSrcD = 2'b01;     // PC+8 plus offset
          immSrcD = 2'b10;
          aluSrcD = 1'b1;
          branchD = 1'b1;
        end
        default: ;
      endcase
    end
  end

  // Execute, bubble on flush or when D is held
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      {regWriteRawE, memWriteE, memtoRegE, branchE, flagWriteE} <= '0;
    end else if (flushE || stallD) begin
      {regWriteRawE, memWriteE, memtoRegE, branchE, flagWriteE} <= '0;
    end else begin
      {regWriteRawE, memWriteE, memtoRegE, branchE, flagWriteE} <=
        {regWriteD, memWriteD, memtoRegD, branchD, flagWriteD};
    end
  end

  always_ff @(posedge clk) begin
    aluSrcE     <= aluSrcD;
    aluControlE <= aluControlD;
    condE       <= instrD.dp.cond;
    rdE         <= instrD.dp.rd;
  end

  condUnit i_condUnit (
    .clk       (clk),
    .arstN     (arstN),
    .condE     (condE),
    .flagWriteE(flagWriteE),
    .aluFlagsE (aluFlagsE),
    .condExE   (condExE)
  );

  assign regWriteE    = regWriteRawE & (aluControlE != `OP_CMP); // CMP only sets flags
  assign branchTakenE = branchE & condExE;

  // Memory and writeback never stall
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      {memWriteM, memtoRegM, regWriteM} <= '0;
      {memtoRegW, regWriteW}            <= '0;
    end else begin
      memWriteM <= memWriteE & condExE;
      memtoRegM <= memtoRegE & condExE;
      regWriteM <= regWriteE & condExE;
      memtoRegW <= memtoRegM;
      regWriteW <= regWriteM;
    end
  end

  always_ff @(posedge clk) begin
    rdM <= rdE;
    rdW <= rdM;
  end

  assign dataReqM = memWriteM | memtoRegM;

endmodule

// File: verilog/datapath.sv
`timescale 1ns/1ps
`include "arm_consts.svh"

module datapath import armIsaPkg::*, armCondPkg::*; (
  input  logic        clk,
  input  logic        arstN,
  input  logic        stallF,
  input  logic        stallD,
  input  logic        flushD,
  input  logic        flushE,
  input  logic [1:0]  regSrcD,
  input  logic [1:0]  immSrcD,
  input  logic        aluSrcE,
  input  logic [3:0]  aluControlE,
  input  logic        branchTakenE,
  input  logic        regWriteW,
  input  logic        memtoRegW,
  input  logic [3:0]  rdW,
  input  logic [31:0] memRdData,
  output logic [31:0] fetchAddr,
  output instrU       instrD,
  output logic [3:0]  rnD,
  output logic [3:0]  rmD,
  output logic [3:0]  aluFlagsE,
  output logic [31:0] dataAddrM,
  output logic [31:0] dataWrDataM
);

  logic [31:0] pcF, pcD, pcPlus8D;
  logic [31:0] rf [0:14]; // R15 is the PC
  logic [31:0] rd1D, rd2D, immExtD;
  logic [31:0] rd1E, rd2E, immExtE, srcBE, aluResultE;
  logic [31:0] aluResultM, wrDataM;
  logic [31:0] aluResultW, readDataW, resultW;

  // Fetch
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) pcF <= `RESET_PC;
    else if (branchTakenE) pcF <= aluResultE; // Branch beats any stall
    else if (!stallF) pcF <= pcF + 32'd4;
  end

  assign fetchAddr = pcF;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) instrD <= {`COND_NV, 28'd0};
    else if (flushD) instrD <= {`COND_NV, 28'd0};
    else if (!stallD) instrD <= memRdData;
  end

  always_ff @(posedge clk) begin
    if (!stallD) pcD <= pcF;
  end

  // Decode and register read
  assign pcPlus8D = pcD + 32'd8;
  assign rnD = regSrcD[0] ? `REG_PC : instrD.dp.rn;
  assign rmD = regSrcD[1] ? instrD.dp.rd : instrD.dp.operand2[3:0];

  assign rd1D = (rnD == `REG_PC) ? pcPlus8D :
                (regWriteW && rdW == rnD) ? resultW : rf[rnD];
  assign rd2D = (rmD == `REG_PC) ? pcPlus8D :
                (regWriteW && rdW == rmD) ? resultW : rf[rmD];

  always_comb begin
    case (immSrcD)
      2'b01:   immExtD = {20'd0, instrD.mem.offset};
      2'b10:   immExtD = {{6{instrD.br.offset[23]}}, instrD.br.offset, 2'b00};
      default: immExtD = {24'd0, instrD.dp.operand2[7:0]};
    endcase
  end

  always_ff @(posedge clk) begin
    if (regWriteW && rdW != `REG_PC) rf[rdW] <= resultW;
  end

  // Execute, zero operands keep the ALU quiet for bubbles
  always_ff @(posedge clk) begin
    if (flushE || stallD) begin
      rd1E    <= 32'd0;
      rd2E    <= 32'd0;
      immExtE <= 32'd0;
    end else begin
      rd1E    <= rd1D;
      rd2E    <= rd2D;
      immExtE <= immExtD;
    end
  end

  assign srcBE = aluSrcE ? immExtE : rd2E;

  always_comb begin
    case (aluControlE)
      `OP_AND:          aluResultE = rd1E & srcBE;
      `OP_EOR:          aluResultE = rd1E ^ srcBE;
      `OP_SUB, `OP_CMP: aluResultE = rd1E - srcBE;
      `OP_ORR:          aluResultE = rd1E | srcBE;
      `OP_MOV:          aluResultE = srcBE;
      default:          aluResultE = rd1E + srcBE; // ADD, addresses, branch target
    endcase
  end

  assign aluFlagsE = aluFlags(aluControlE, rd1E, srcBE, aluResultE);

  // Memory and writeback
  always_ff @(posedge clk) begin
    aluResultM <= aluResultE;
    wrDataM    <= rd2E;
    aluResultW <= aluResultM;
    readDataW  <= memRdData; // Load data arrives while M owns the port
  end

  assign dataAddrM   = aluResultM;
  assign dataWrDataM = wrDataM;
  assign resultW     = memtoRegW ? readDataW : aluResultW;

endmodule

// File: verilog/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
  input  logic [3:0] rnD,
  input  logic [3:0] rmD,
  input  logic       usesRnD,
  input  logic       usesRmD,
  input  logic [3:0] rdE,
  input  logic [3:0] rdM,
  input  logic       regWriteE,
  input  logic       regWriteM,
  input  logic       branchTakenE,
  input  logic       fetchGrant,
  output logic       stallF,
  output logic       stallD,
  output logic       flushD,
  output logic       flushE
);

  logic rnHit, rmHit;
  logic rawStall;

  // W is covered by the register file write-through
  assign rnHit = (regWriteE && rnD == rdE) || (regWriteM && rnD == rdM);
  assign rmHit = (regWriteE && rmD == rdE) || (regWriteM && rmD == rdM);
  assign rawStall = (usesRnD && rnHit) || (usesRmD && rmHit);

  // Lost fetch slot holds F and D like a RAW stall
  assign stallF = rawStall | ~fetchGrant;
  assign stallD = rawStall | ~fetchGrant;

  // Wrong-path instructions in D and E
  assign flushD = branchTakenE;
  assign flushE = branchTakenE;

endmodule

// File: verilog/memArbiter.sv
`timescale 1ns/1ps

module memArbiter (
  input  logic [31:0] fetchAddr,
  input  logic        dataReq,
  input  logic [31:0] dataAddr,
  input  logic        dataWrEn,
  input  logic [31:0] dataWrData,
  output logic [31:0] memAddr,
  output logic        memWrEn,
  output logic [31:0] memWrData,
  output logic        fetchGrant
);

  // Memory stage always wins, fetch takes the idle slots
  assign fetchGrant = ~dataReq;
  assign memAddr    = dataReq ? dataAddr : fetchAddr;
  assign memWrEn    = dataReq & dataWrEn;
  assign memWrData  = dataWrData;

endmodule

// File: verilog/armCore.sv
`timescale 1ns/1ps

module armCore import armIsaPkg::*; (
  input  logic        clk,
  input  logic        arstN,
  output logic [31:0] memAddr,
  output logic        memWrEn,
  output logic [31:0] memWrData,
  input  logic [31:0] memRdData
);

  instrU       instrD;
  logic [3:0]  aluFlagsE, aluControlE;
  logic [1:0]  regSrcD, immSrcD;
  logic        aluSrcE, branchTakenE;
  logic        memWriteM, dataReqM, memtoRegW;
  logic        regWriteE, regWriteM, regWriteW;
  logic [3:0]  rdE, rdM, rdW, rnD, rmD;
  logic        usesRnD, usesRmD;
  logic        stallF, stallD, flushD, flushE;
  logic [31:0] fetchAddr, dataAddrM, dataWrDataM;
  logic        fetchGrant;

  controller i_controller (.*);

  datapath i_datapath (.*);

  hazardUnit i_hazardUnit (.*);

  // Fetch and memory stage share the one port
  memArbiter i_memArbiter (
    .fetchAddr (fetchAddr),
    .dataReq   (dataReqM),
    .dataAddr  (dataAddrM),
    .dataWrEn  (memWriteM),
    .dataWrData(dataWrDataM),
    .memAddr   (memAddr),
    .memWrEn   (memWrEn),
    .memWrData (memWrData),
    .fetchGrant(fetchGrant)
  );

endmodule

// File: testbench/armCore_chk.sv
`timescale 1ns/1ps

module armCore_chk (
  input logic        clk,
  input logic        arstN,
  input logic [31:0] fetchAddr,
  input logic        dataReq,
  input logic        memWrEn,
  input logic        memWriteM,
  input logic        regWriteW,
  input logic        branchTakenE
);

  // Losing the port to the memory stage holds the PC
  fetchHeld: assert property (@(posedge clk) disable iff (!arstN)
    (dataReq && !branchTakenE) |=> fetchAddr == $past(fetchAddr))
    else $error("PC advanced while the memory stage held the port");

  // The flushed wrong-path slot never reaches the port
  wrongPathQuiet: assert property (@(posedge clk) disable iff (!arstN)
    $past(branchTakenE, 2) |-> !dataReq)
    else $error("memory access two cycles after a taken branch");

  quietInReset: assert property (@(posedge clk)
    !arstN |-> !(memWrEn || memWriteM || regWriteW))
    else $error("write enable high during reset");

  // Flush of E turns the next slot into a bubble
  singleBranch: assert property (@(posedge clk) disable iff (!arstN)
    branchTakenE |=> !branchTakenE)
    else $error("branch taken in two consecutive cycles");

endmodule

bind armCore armCore_chk i_armCore_chk (
  .clk         (clk),
  .arstN       (arstN),
  .fetchAddr   (fetchAddr),
  .dataReq     (dataReqM),
  .memWrEn     (memWrEn),
  .memWriteM   (memWriteM),
  .regWriteW   (regWriteW),
  .branchTakenE(branchTakenE)
);

// File: testbench/armCore_tb.sv
`timescale 1ns/1ps
`include "arm_consts.svh"

module armCore_tb import armIsaPkg::*, armCondPkg::*; ();

  localparam logic [31:0] END_ADDR = 32'h0000_0FFC; // Store here ends a program
  localparam int TIMEOUT_CYCLES = 20000;

  logic        clk;
  logic        arstN;
  logic [31:0] memAddr;
  logic        memWrEn;
  logic [31:0] memWrData;
  logic [31:0] memRdData;

  logic [31:0] mem [0:`MEM_WORDS-1];
  logic [31:0] refMem [0:`MEM_WORDS-1];
  logic [31:0] prog [$];
  logic [31:0] expAddr [$];
  logic [31:0] expData [$];
  int          expIdx;
  bit          storesDone;
  logic [31:0] lcgState = 32'd21232;

  armCore i_armCore (
    .clk      (clk),
    .arstN    (arstN),
    .memAddr  (memAddr),
    .memWrEn  (memWrEn),
    .memWrData(memWrData),
    .memRdData(memRdData)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Unified memory with a combinational read
  assign memRdData = mem[memAddr[11:2]];

  always @(posedge clk) begin
    if (memWrEn) mem[memAddr[11:2]] <= memWrData;
  end

  task automatic abortRun(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abortRun($sformatf("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return {8'd0, lcgState[31:8]};
  endfunction

  function automatic logic [31:0] fillWord(input int i);
    return 32'hC3A5_0F1E ^ (32'(i) * 32'h9E37_79B9);
  endfunction

  // Instruction encoders
  function automatic logic [31:0] aluImm(input logic [3:0] cond, input logic [3:0] op,
                                          input bit s, input int rd, input int rn, input int imm);
    instrU w;
    w = '0;
    w.dp.cond     = cond;
    w.dp.cls      = `CLASS_DP;
    w.dp.imm      = 1'b1;
    w.dp.opcode   = op;
    w.dp.s        = s;
    w.dp.rn       = 4'(rn);
    w.dp.rd       = 4'(rd);
    w.dp.operand2 = 12'(imm & 255);
    return w;
  endfunction

  function automatic logic [31:0] aluReg(input logic [3:0] cond, input logic [3:0] op,
                                          input bit s, input int rd, input int rn, input int rm);
    instrU w;
    w = '0;
    w.dp.cond     = cond;
    w.dp.cls      = `CLASS_DP;
    w.dp.opcode   = op;
    w.dp.s        = s;
    w.dp.rn       = 4'(rn);
    w.dp.rd       = 4'(rd);
    w.dp.operand2 = 12'(rm);
    return w;
  endfunction

  function automatic logic [31:0] memWord(input logic [3:0] cond, input bit l, input bit u,
                                           input int rd, input int rn, input int off);
    instrU w;
    w = '0;
    w.mem.cond   = cond;
    w.mem.cls    = `CLASS_MEM;
    w.mem.p      = 1'b1; // Offset addressing
    w.mem.u      = u;
    w.mem.l      = l;
    w.mem.rn     = 4'(rn);
    w.mem.rd     = 4'(rd);
    w.mem.offset = 12'(off);
    return w;
  endfunction

  function automatic logic [31:0] brWord(input logic [3:0] cond, input int off);
    instrU w;
    w = '0;
    w.br.cond   = cond;
    w.br.cls    = `CLASS_BR;
    w.br.one    = 1'b1;
    w.br.offset = 24'(off);
    return w;
  endfunction

  task automatic emit(input logic [31:0] w);
    prog.push_back(w);
  endtask

  // ISA-level interpreter that fills the expected store queues
  function automatic bit runArmRef();
    logic [31:0] regs [0:15];
    logic [31:0] pc, nextPc, a, b, res, addr;
    logic [3:0]  nzcv, f, op;
    instrU       ins;
    int          steps;
    bit          running;
    for (int i = 0; i < 16; i++) regs[i] = 32'd0;
    nzcv = 4'd0;
    pc = `RESET_PC;
    running = 1'b1;
    steps = 0;
    while (running && steps < 10000) begin
      ins = refMem[pc[11:2]];
      regs[15] = pc + 32'd8; // R15 reads as PC+8
      nextPc = pc + 32'd4;
      steps++;
      if (condPassed(ins.dp.cond, nzcv)) begin
        case (ins.dp.cls)
          `CLASS_DP: begin
            op = ins.dp.opcode;
            a = regs[ins.dp.rn];
            b = ins.dp.imm ? {24'd0, ins.dp.operand2[7:0]} : regs[ins.dp.operand2[3:0]];
            case (op)
              `OP_AND:          res = a & b;
              `OP_EOR:          res = a ^ b;
              `OP_SUB, `OP_CMP: res = a - b;
              `OP_ORR:          res = a | b;
              `OP_MOV:          res = b;
              default:          res = a + b;
            endcase
            if (ins.dp.s) begin
              f = aluFlags(op, a, b, res);
              nzcv[3:2] = f[3:2];
              if (op inside {`OP_ADD, `OP_SUB, `OP_CMP}) nzcv[1:0] = f[1:0];
            end
            if (op != `OP_CMP) regs[ins.dp.rd] = res;
          end
          `CLASS_MEM: begin
            a = regs[ins.mem.rn];
            addr = ins.mem.u ? a + {20'd0, ins.mem.offset} : a - {20'd0, ins.mem.offset};
            if (ins.mem.l) begin
              regs[ins.mem.rd] = refMem[addr[11:2]];
            end else begin
              refMem[addr[11:2]] = regs[ins.mem.rd];
              expAddr.push_back(addr);
              expData.push_back(regs[ins.mem.rd]);
              if (addr == END_ADDR) running = 1'b0;
            end
          end
          `CLASS_BR: nextPc = pc + 32'd8 + {{6{ins.br.offset[23]}}, ins.br.offset, 2'b00};
          default: ;
        endcase
      end
      pc = nextPc;
    end
    return !running;
  endfunction

  // Every register gets a known value and r12 is the zero base
  task automatic addPrologue();
    prog.delete();
    for (int r = 0; r < 12; r++) emit(aluImm(`COND_AL, `OP_MOV, 1'b0, r, 0, 17 * r + 5));
    emit(aluImm(`COND_AL, `OP_MOV, 1'b0, 12, 0, 0));
  endtask

  task automatic addEpilogue();
    for (int r = 0; r < 12; r++) emit(memWord(`COND_AL, 1'b0, 1'b1, r, 12, 'h900 + 4 * r));
    emit(memWord(`COND_AL, 1'b0, 1'b1, 0, 12, int'(END_ADDR)));
  endtask

  task automatic buildArith();
    addPrologue();
    emit(aluReg(`COND_AL, `OP_ADD, 1'b0, 1, 2, 3));
    emit(aluImm(`COND_AL, `OP_SUB, 1'b0, 4, 1, 7));  // Depends on previous
    emit(aluReg(`COND_AL, `OP_EOR, 1'b0, 5, 4, 1));
    emit(aluImm(`COND_AL, `OP_AND, 1'b0, 6, 5, 'h3C));
    emit(aluReg(`COND_AL, `OP_ORR, 1'b0, 7, 6, 2));
    emit(aluReg(`COND_AL, `OP_MOV, 1'b0, 8, 0, 7));
    emit(aluReg(`COND_AL, `OP_SUB, 1'b0, 9, 8, 11));
    emit(memWord(`COND_AL, 1'b0, 1'b1, 9, 12, 'h800));
    addEpilogue();
  endtask

  task automatic buildCond();
    addPrologue();
    emit(aluImm(`COND_AL, `OP_MOV, 1'b0, 0, 0, 5));
    emit(aluImm(`COND_AL, `OP_CMP, 1'b1, 0, 0, 5));
    emit(aluImm(`COND_EQ, `OP_ADD, 1'b0, 1, 1, 1));
    emit(aluImm(`COND_NE, `OP_ADD, 1'b0, 2, 2, 1)); // Skipped
    emit(aluImm(`COND_AL, `OP_SUB, 1'b1, 3, 0, 6)); // Negative, no carry
    emit(aluImm(`COND_MI, `OP_MOV, 1'b0, 4, 0, 'h44));
    emit(aluImm(`COND_PL, `OP_MOV, 1'b0, 5, 0, 'h55));
    emit(memWord(`COND_NE, 1'b0, 1'b1, 0, 12, 'h880));
    emit(memWord(`COND_EQ, 1'b0, 1'b1, 1, 12, 'h884));
    emit(aluImm(`COND_AL, `OP_AND, 1'b1, 6, 0, 0)); // Z set, C kept
    emit(aluImm(`COND_CS, `OP_ORR, 1'b0, 7, 7, 1));
    emit(aluImm(`COND_CC, `OP_MOV, 1'b0, 8, 0, 'h88));
    emit(aluImm(`COND_AL, `OP_CMP, 1'b1, 0, 0, 3));
    emit(aluImm(`COND_GT, `OP_ADD, 1'b0, 9, 9, 9));
    emit(aluImm(`COND_LT, `OP_ADD, 1'b0, 10, 10, 10));
    addEpilogue();
  endtask

  task automatic buildLoad();
    addPrologue();
    emit(memWord(`COND_AL, 1'b0, 1'b1, 1, 12, 'h840));
    emit(memWord(`COND_AL, 1'b1, 1'b1, 2, 12, 'h840));
    emit(aluReg(`COND_AL, `OP_ADD, 1'b0, 3, 2, 2)); // Load use
    emit(memWord(`COND_AL, 1'b1, 1'b1, 4, 12, 'hA00));
    emit(memWord(`COND_AL, 1'b0, 1'b1, 4, 12, 'h844));
    emit(memWord(`COND_AL, 1'b1, 1'b1, 5, 12, 'h844));
    emit(aluImm(`COND_AL, `OP_ADD, 1'b0, 6, 5, 1));
    emit(memWord(`COND_AL, 1'b0, 1'b1, 6, 12, 'h848));
    emit(memWord(`COND_AL, 1'b1, 1'b0, 7, 12, 'h10)); // Downward offset wraps
    addEpilogue();
  endtask

  task automatic buildBranch();
    int loopIdx;
    addPrologue();
    emit(aluReg(`COND_AL, `OP_CMP, 1'b1, 0, 0, 0));
    emit(brWord(`COND_NE, 1)); // Not taken
    emit(aluImm(`COND_AL, `OP_ADD, 1'b0, 1, 1, 1));
    emit(aluImm(`COND_AL, `OP_ADD, 1'b0, 2, 2, 2));
    emit(brWord(`COND_EQ, 1)); // Taken over two words
    emit(memWord(`COND_AL, 1'b0, 1'b1, 3, 12, 'h8F0));
    emit(aluImm(`COND_AL, `OP_MOV, 1'b0, 4, 0, 'hEE));
    emit(aluImm(`COND_AL, `OP_ADD, 1'b0, 5, 5, 5));
    emit(aluImm(`COND_AL, `OP_MOV, 1'b0, 9, 0, 3));
    loopIdx = prog.size();
    emit(aluImm(`COND_AL, `OP_ADD, 1'b0, 10, 10, 2));
    emit(aluImm(`COND_AL, `OP_SUB, 1'b1, 9, 9, 1));
    emit(brWord(`COND_NE, loopIdx - (prog.size() + 2))); // Backward loop
    emit(brWord(`COND_AL, 0));
    emit(aluImm(`COND_AL, `OP_MOV, 1'b0, 11, 0, 'h77));
    addEpilogue();
  endtask

  task automatic buildRandom();
    logic [31:0] rnd, rnd2;
    logic [3:0]  ops [0:6];
    logic [3:0]  op, cond;
    int          rd, rn, rm;
    ops[0] = `OP_AND;
    ops[1] = `OP_EOR;
    ops[2] = `OP_SUB;
    ops[3] = `OP_ADD;
    ops[4] = `OP_ORR;
    ops[5] = `OP_MOV;
    ops[6] = `OP_CMP;
    addPrologue();
    repeat (40) begin
      rnd  = nextRand();
      rnd2 = nextRand();
      cond = (rnd[1:0] == 2'd0) ? rnd[5:2] % 4'd14 : `COND_AL;
      rd   = int'(rnd[9:6] % 4'd12); // r12 stays the base
      rn   = int'(rnd[13:10] % 4'd12);
      rm   = int'(rnd[17:14] % 4'd12);
      op   = ops[rnd[20:18] % 3'd7];
      if (rnd[23:21] < 3'd6) begin
        if (rnd[24]) emit(aluImm(cond, op, rnd[25] | (op == `OP_CMP), rd, rn, int'(rnd2[7:0])));
        else emit(aluReg(cond, op, rnd[25] | (op == `OP_CMP), rd, rn, rm));
      end else begin
        emit(memWord(cond, rnd[24], 1'b1, rd, 12, 'h800 + 4 * int'(rnd2[5:0])));
      end
    end
    addEpilogue();
  endtask

  task automatic runProgram(input string name);
    int cycles;
    arstN = 1'b0;
    for (int i = 0; i < `MEM_WORDS; i++) mem[i] = fillWord(i);
    for (int i = 0; i < prog.size(); i++) mem[i] = prog[i];
    for (int i = 0; i < `MEM_WORDS; i++) refMem[i] = mem[i];
    expAddr.delete();
    expData.delete();
    expIdx = 0;
    storesDone = 1'b0;
    if (!runArmRef()) abortRun($sformatf("%s program never reaches its end store", name));
    repeat (10) @(negedge clk);
    arstN = 1'b1;
    cycles = 0;
    while (!storesDone && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (!storesDone) abortRun($sformatf("Timeout waiting for the end store of %s program", name));
    $display("%s program: %0d stores matched", name, expIdx);
    arstN = 1'b0; // Stop before the fill words execute
  endtask

  // Store checker
  always @(posedge clk) begin
    if (arstN && memWrEn) begin
      if (expIdx >= expAddr.size()) begin
        abortRun("DUT stored more words than the reference model");
      end else begin
        checkVal("memAddr", memAddr, expAddr[expIdx]);
        checkVal("memWrData", memWrData, expData[expIdx]);
        expIdx++;
        if (memAddr == END_ADDR) storesDone = 1'b1;
      end
    end
  end

  initial begin
    arstN = 1'b0;
    buildArith();
    runProgram("arithmetic");
    buildCond();
    runProgram("condition");
    buildLoad();
    runProgram("load/store");
    buildBranch();
    runProgram("branch");
    for (int n = 0; n < 3; n++) begin
      buildRandom();
      runProgram($sformatf("random %0d", n));
    end
    $display("Test OK");
    $finish;
  end

endmodule

// File: sim.f
+incdir+common
common/armIsaPkg.sv
common/armCondPkg.sv
controller/condUnit.sv
controller/controller.sv
verilog/datapath.sv
verilog/hazardUnit.sv
verilog/memArbiter.sv
verilog/armCore.sv
testbench/armCore_chk.sv
testbench/armCore_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= armCore_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "Test OK" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
